/* Makefile */
VERILATOR ?= verilator
TOP       ?= io_bus_tb
RTL_TOP   ?= io_bus_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* rtl/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port #(
  parameter int GPIO_W = 8
) (
  input  logic                clk,
  input  logic                reset_button,
  input  logic                gpio_out_wr,
  input  logic                gpio_dir_wr,
  input  io_pkg::modify_op_e  op,
  input  io_pkg::word_t       wr_data,
  input  logic [GPIO_W-1:0]   gpio_in,
  output logic [GPIO_W-1:0]   gpio_out,
  output logic [GPIO_W-1:0]   gpio_oe,    // 1 drives the pin
  output logic [GPIO_W-1:0]   gpio_in_q
);

  io_pkg::word_t out_next;
  io_pkg::word_t dir_next;

  // Modify result computed on full bus words
  assign out_next = io_pkg::apply_modify(io_pkg::word_t'(gpio_out), wr_data, op);
  assign dir_next = io_pkg::apply_modify(io_pkg::word_t'(gpio_oe), wr_data, op);

  // Output and direction registers
  always_ff @(posedge clk) begin
    if (reset_button) begin
      gpio_out <= '0;
      gpio_oe  <= '0;  // All pins inputs after reset
    end else begin
      if (gpio_out_wr) begin
        gpio_out <= out_next[GPIO_W-1:0];
      end
      if (gpio_dir_wr) begin
        gpio_oe <= dir_next[GPIO_W-1:0];
      end
    end
  end

  // Pin sample, readable one cycle after a change
  always_ff @(posedge clk) begin
    if (reset_button) begin
      gpio_in_q <= '0;
    end else begin
      gpio_in_q <= gpio_in;
    end
  end

endmodule

/* rtl/io_bus_decode.sv */
`timescale 1ns/1ps

module io_bus_decode #(
  parameter int GPIO_W = 8
) (
  input  io_pkg::word_t               addr,
  input  io_pkg::word_t               wr_data,
  input  logic                        wr,
  input  logic [GPIO_W-1:0]           gpio_in_q,
  input  logic [GPIO_W-1:0]           gpio_out_q,
  input  logic [GPIO_W-1:0]           gpio_dir_q,
  input  logic [io_pkg::LED_W-1:0]    leds_q,
  input  io_pkg::word_t               sdm_red_q,
  input  io_pkg::word_t               sdm_green_q,
  input  io_pkg::word_t               sdm_blue_q,
  input  io_pkg::word_t               ticks_q,
  input  io_pkg::word_t               cycles_q,
  output logic                        gpio_out_wr,
  output logic                        gpio_dir_wr,
  output logic                        ticks_wr,
  output logic                        led_wr,
  output logic [2:0]                  sdm_wr,    // 0 red, 1 green, 2 blue
  output io_pkg::modify_op_e          op,
  output io_pkg::word_t               rd_data
);

  io_pkg::sub_sel_e sub_sel;
  logic             group;

  // Sub-select field only means something with the group bit set
  assign sub_sel = io_pkg::sub_sel_e'(addr[7:4]);
  assign group   = addr[io_pkg::A_GROUP];
  assign op      = io_pkg::modify_op_e'(addr[1:0]);  // Low bits pick the modify op

  logic sel_leds;
  logic sel_red;
  logic sel_green;
  logic sel_blue;

  assign sel_leds  = group & (sub_sel == io_pkg::SEL_LEDS);
  assign sel_red   = group & (sub_sel == io_pkg::SEL_SDM_RED);
  assign sel_green = group & (sub_sel == io_pkg::SEL_SDM_GREEN);
  assign sel_blue  = group & (sub_sel == io_pkg::SEL_SDM_BLUE);

  // Write strobes, one cycle wide like wr itself
  assign gpio_out_wr = wr & addr[io_pkg::A_GPIO_OUT];
  assign gpio_dir_wr = wr & addr[io_pkg::A_GPIO_DIR];
  assign ticks_wr    = wr & addr[io_pkg::A_TICKS];
  assign led_wr      = wr & sel_leds;
  assign sdm_wr      = {wr & sel_blue, wr & sel_green, wr & sel_red};

  // Narrow sources zero-extended to a bus word
  io_pkg::word_t gpio_in_w;
  io_pkg::word_t gpio_out_w;
  io_pkg::word_t gpio_dir_w;
  io_pkg::word_t leds_w;

  assign gpio_in_w  = io_pkg::word_t'(gpio_in_q);
  assign gpio_out_w = io_pkg::word_t'(gpio_out_q);
  assign gpio_dir_w = io_pkg::word_t'(gpio_dir_q);
  assign leds_w     = io_pkg::word_t'(leds_q);

  // Read-back is the OR of every selected source
  // Several address bits at once read several registers together
  always_comb begin
    rd_data = '0;
    if (addr[io_pkg::A_GPIO_IN])  rd_data = rd_data | gpio_in_w;
    if (addr[io_pkg::A_GPIO_OUT]) rd_data = rd_data | gpio_out_w;
    if (addr[io_pkg::A_GPIO_DIR]) rd_data = rd_data | gpio_dir_w;
    if (sel_leds)                 rd_data = rd_data | leds_w;
    if (sel_red)                  rd_data = rd_data | sdm_red_q;
    if (sel_green)                rd_data = rd_data | sdm_green_q;
    if (sel_blue)                 rd_data = rd_data | sdm_blue_q;
    if (addr[io_pkg::A_TICKS])    rd_data = rd_data | ticks_q;
    if (addr[io_pkg::A_CYCLES])   rd_data = rd_data | cycles_q;  // Free-running count
  end

endmodule

/* rtl/io_bus_top.sv */
`timescale 1ns/1ps

module io_bus_top #(
  parameter int GPIO_W = 8,
  parameter int SDM_W  = 16
) (
  input  logic               clk,
  input  logic               reset_button,
  input  io_pkg::word_t      addr,
  input  io_pkg::word_t      wr_data,
  input  logic               wr,          // Single-cycle write strobe
  output io_pkg::word_t      rd_data,     // Combinational from addr
  input  logic [GPIO_W-1:0]  gpio_in,
  output logic [GPIO_W-1:0]  gpio_out,
  output logic [GPIO_W-1:0]  gpio_oe,
  output logic               interrupt,
  output logic               led_red,
  output logic               led_green,
  output logic               led_blue
);

  // Strobes from the decoder
  logic                      gpio_out_wr;
  logic                      gpio_dir_wr;
  logic                      ticks_wr;
  logic                      led_wr;
  logic [2:0]                sdm_wr;
  io_pkg::modify_op_e        op;

  // Register values back to the read mux
  logic [GPIO_W-1:0]         gpio_in_q;
  logic [io_pkg::LED_W-1:0]  leds_q;
  io_pkg::word_t             sdm_red_q;
  io_pkg::word_t             sdm_green_q;
  io_pkg::word_t             sdm_blue_q;
  io_pkg::word_t             ticks_q;
  io_pkg::word_t             cycles_q;

  io_bus_decode #(.GPIO_W(GPIO_W)) decode_i (
    .addr        (addr),
    .wr_data     (wr_data),
    .wr          (wr),
    .gpio_in_q   (gpio_in_q),
    .gpio_out_q  (gpio_out),
    .gpio_dir_q  (gpio_oe),
    .leds_q      (leds_q),
    .sdm_red_q   (sdm_red_q),
    .sdm_green_q (sdm_green_q),
    .sdm_blue_q  (sdm_blue_q),
    .ticks_q     (ticks_q),
    .cycles_q    (cycles_q),
    .gpio_out_wr (gpio_out_wr),
    .gpio_dir_wr (gpio_dir_wr),
    .ticks_wr    (ticks_wr),
    .led_wr      (led_wr),
    .sdm_wr      (sdm_wr),
    .op          (op),
    .rd_data     (rd_data)
  );

  gpio_port #(.GPIO_W(GPIO_W)) gpio_i (
    .clk          (clk),
    .reset_button (reset_button),
    .gpio_out_wr  (gpio_out_wr),
    .gpio_dir_wr  (gpio_dir_wr),
    .op           (op),
    .wr_data      (wr_data),
    .gpio_in      (gpio_in),
    .gpio_out     (gpio_out),
    .gpio_oe      (gpio_oe),
    .gpio_in_q    (gpio_in_q)
  );

  tick_timer timer_i (
    .clk          (clk),
    .reset_button (reset_button),
    .ticks_wr     (ticks_wr),
    .wr_data      (wr_data),
    .ticks_q      (ticks_q),
    .cycles_q     (cycles_q),
    .interrupt    (interrupt)
  );

  led_modulator #(.SDM_W(SDM_W)) led_i (
    .clk          (clk),
    .reset_button (reset_button),
    .led_wr       (led_wr),
    .sdm_wr       (sdm_wr),
    .op           (op),
    .wr_data      (wr_data),
    .leds_q       (leds_q),
    .sdm_red_q    (sdm_red_q),
    .sdm_green_q  (sdm_green_q),
    .sdm_blue_q   (sdm_blue_q),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue)
  );

endmodule

/* rtl/io_pkg.sv */
package io_pkg;

  // Bus word width, shared by address and data
  parameter int DATA_W = 16;
  parameter int LED_W  = 4;  // LED register width

  typedef logic [DATA_W-1:0] word_t;

  // One-hot address bits
  parameter int A_GPIO_IN  = 8;
  parameter int A_GPIO_OUT = 9;
  parameter int A_GPIO_DIR = 10;
  parameter int A_GROUP    = 11;  // Sub-select group in bits 7:4
  parameter int A_TICKS    = 14;
  parameter int A_CYCLES   = 15;

  // Modify opcode from address bits 1:0
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,  // Plain write
    OP_CLEAR  = 2'd1,
    OP_SET    = 2'd2,
    OP_TOGGLE = 2'd3
  } modify_op_e;

  // Sub-select inside the group
  typedef enum logic [3:0] {
    SEL_LEDS      = 4'd11,
    SEL_SDM_RED   = 4'd12,
    SEL_SDM_GREEN = 4'd13,
    SEL_SDM_BLUE  = 4'd14
  } sub_sel_e;

  // New register value for a modify write
  function automatic word_t apply_modify(word_t old_val, word_t data, modify_op_e op);
    word_t result;
    case (op)
      OP_WRITE:  result = data;
      OP_CLEAR:  result = old_val & ~data;  // Clear bits set in data
      OP_SET:    result = old_val | data;
      OP_TOGGLE: result = old_val ^ data;   // Invert bits set in data
      default:   result = old_val;
    endcase
    return result;
  endfunction

endpackage

/* rtl/led_modulator.sv */
`timescale 1ns/1ps

module led_modulator #(
  parameter int SDM_W = 16  // Accumulator width, at most DATA_W
) (
  input  logic                      clk,
  input  logic                      reset_button,
  input  logic                      led_wr,
  input  logic [2:0]                sdm_wr,      // 0 red, 1 green, 2 blue
  input  io_pkg::modify_op_e        op,
  input  io_pkg::word_t             wr_data,
  output logic [io_pkg::LED_W-1:0]  leds_q,
  output io_pkg::word_t             sdm_red_q,
  output io_pkg::word_t             sdm_green_q,
  output io_pkg::word_t             sdm_blue_q,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue
);

  io_pkg::word_t     leds_next;
  io_pkg::word_t     level [3];   // Colour levels as written
  logic [SDM_W-1:0]  phase [3];   // Phase accumulators
  logic [SDM_W:0]    sum   [3];
  logic [2:0]        carry;       // Registered modulator bits

  assign leds_next = io_pkg::apply_modify(io_pkg::word_t'(leds_q), wr_data, op);

  // Accumulator only sees the low SDM_W bits of the level
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      sum[c] = {1'b0, phase[c]} + {1'b0, level[c][SDM_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_button) begin
      leds_q <= '0;
      carry  <= '0;
      for (int c = 0; c < 3; c++) begin
        level[c] <= '0;
        phase[c] <= '0;
      end
    end else begin
      if (led_wr) begin
        leds_q <= leds_next[io_pkg::LED_W-1:0];  // Modify ops like the port
      end
      for (int c = 0; c < 3; c++) begin
        if (sdm_wr[c]) begin
          level[c] <= wr_data;
        end
        // Carry density over 2**SDM_W cycles equals the level
        {carry[c], phase[c]} <= sum[c];
      end
    end
  end

  assign sdm_red_q   = level[0];
  assign sdm_green_q = level[1];
  assign sdm_blue_q  = level[2];

  // LED bit forces its colour on
  assign led_red   = carry[0] | leds_q[0];
  assign led_green = carry[1] | leds_q[1];
  assign led_blue  = carry[2] | leds_q[2];

endmodule

/* rtl/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer (
  input  logic           clk,
  input  logic           reset_button,
  input  logic           ticks_wr,
  input  io_pkg::word_t  wr_data,
  output io_pkg::word_t  ticks_q,
  output io_pkg::word_t  cycles_q,
  output logic           interrupt
);

  logic [io_pkg::DATA_W:0] ticks_plus_1;  // Extra bit holds the carry

  assign ticks_plus_1 = {1'b0, ticks_q} + 1'b1;

  // Loadable timer
  // Carry still registers when a write lands on 0xFFFF
  always_ff @(posedge clk) begin
    if (reset_button) begin
      ticks_q   <= '0;
      interrupt <= 1'b0;
    end else begin
      if (ticks_wr) begin
        ticks_q <= wr_data;
      end else begin
        ticks_q <= ticks_plus_1[io_pkg::DATA_W-1:0];
      end
      interrupt <= ticks_plus_1[io_pkg::DATA_W];  // High while timer reads 0
    end
  end

  // Free-running cycle counter
  always_ff @(posedge clk) begin
    if (reset_button) begin
      cycles_q <= '0;
    end else begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

endmodule

/* test/io_bus_properties.sv */
`timescale 1ns/1ps

module io_bus_properties #(
  parameter int GPIO_W = 8
) (
  input logic               clk,
  input logic               reset_button,
  input io_pkg::word_t      addr,
  input io_pkg::word_t      rd_data,
  input logic [GPIO_W-1:0]  gpio_oe,
  input logic               interrupt,
  input logic               led_red,
  input logic               led_green,
  input logic               led_blue
);

  // Address that selects the timer alone
  localparam io_pkg::word_t TICKS_ADDR = io_pkg::word_t'(1) << io_pkg::A_TICKS;

  // Timer has just wrapped whenever the interrupt is up
  timer_zero_on_interrupt: assert property (
    @(posedge clk) disable iff (reset_button)
    (interrupt && addr == TICKS_ADDR) |-> rd_data == '0
  ) else $error("Timer read back nonzero while interrupt is high");

  // Second reset cycle onward, all registers already cleared
  colours_dark_in_reset: assert property (
    @(posedge clk) (reset_button && $past(reset_button)) |-> !(led_red || led_green || led_blue)
  ) else $error("Colour output high during reset");

  port_input_after_reset: assert property (
    @(posedge clk) $fell(reset_button) |-> gpio_oe == '0
  ) else $error("Port direction not all inputs right after reset");

endmodule

bind io_bus_top io_bus_properties #(.GPIO_W(GPIO_W)) props_i (
  .clk          (clk),
  .reset_button (reset_button),
  .addr         (addr),
  .rd_data      (rd_data),
  .gpio_oe      (gpio_oe),
  .interrupt    (interrupt),
  .led_red      (led_red),
  .led_green    (led_green),
  .led_blue     (led_blue)
);

/* test/io_bus_tb.sv */
`timescale 1ns/1ps

module io_bus_tb;

  localparam int GPIO_W = 8;
  localparam int SDM_W  = 8;  // Short modulator period, 256 cycles

  logic               clk;
  logic               reset_button;
  io_pkg::word_t      addr;
  io_pkg::word_t      wr_data;
  logic               wr;
  io_pkg::word_t      rd_data;
  logic [GPIO_W-1:0]  gpio_in;
  logic [GPIO_W-1:0]  gpio_out;
  logic [GPIO_W-1:0]  gpio_oe;
  logic               interrupt;
  logic               led_red;
  logic               led_green;
  logic               led_blue;

  int                        value_errors;
  int                        timeout_errors;
  string                     test_name;
  logic [31:0]               lcg_state;
  logic [GPIO_W-1:0]         model_out;   // Expected port registers
  logic [GPIO_W-1:0]         model_dir;
  logic [io_pkg::LED_W-1:0]  model_leds;

  io_bus_top #(.GPIO_W(GPIO_W), .SDM_W(SDM_W)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic io_pkg::word_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];  // Upper half, longer period
  endfunction

  // Reference rule for the four modify ops
  function automatic io_pkg::word_t modify_model(io_pkg::word_t old_val, io_pkg::word_t data,
                                                 io_pkg::modify_op_e op);
    case (op)
      io_pkg::OP_CLEAR:  return old_val & ~data;
      io_pkg::OP_SET:    return old_val | data;
      io_pkg::OP_TOGGLE: return old_val ^ data;
      default:           return data;
    endcase
  endfunction

  function automatic io_pkg::word_t bit_addr(int pos);
    return io_pkg::word_t'(1) << pos;
  endfunction

  function automatic io_pkg::word_t group_addr(io_pkg::sub_sel_e sel, io_pkg::modify_op_e op);
    return bit_addr(io_pkg::A_GROUP) | {8'h00, sel, 2'b00, op};
  endfunction

  task automatic check_word(string what, io_pkg::word_t exp, io_pkg::word_t act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_gpio(string what, logic [GPIO_W-1:0] exp, logic [GPIO_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  // Bus tasks start and end 5 ns after a rising edge
  task automatic bus_write(io_pkg::word_t a, io_pkg::word_t d);
    addr    = a;
    wr_data = d;
    wr      = 1'b1;
    @(posedge clk);
    #5;
    wr      = 1'b0;  // Register already updated here
  endtask

  task automatic bus_read(io_pkg::word_t a, output io_pkg::word_t d);
    addr = a;
    #30;
    d = rd_data;  // Just before the next edge
    @(posedge clk);
    #5;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic port_modify_test();
    io_pkg::modify_op_e op;
    io_pkg::word_t      data;
    io_pkg::word_t      next;
    io_pkg::word_t      rd;
    test_name = "port_modify";
    // Bit 0 picks out or dir, bits 2:1 the op, so both see all four ops
    for (int i = 0; i < 16; i++) begin
      op   = io_pkg::modify_op_e'(i[2:1]);
      data = rand_word();
      if (i[0] == 1'b0) begin
        bus_write(bit_addr(io_pkg::A_GPIO_OUT) | io_pkg::word_t'(op), data);
        next      = modify_model(io_pkg::word_t'(model_out), data, op);
        model_out = next[GPIO_W-1:0];
      end else begin
        bus_write(bit_addr(io_pkg::A_GPIO_DIR) | io_pkg::word_t'(op), data);
        next      = modify_model(io_pkg::word_t'(model_dir), data, op);
        model_dir = next[GPIO_W-1:0];
      end
      check_gpio("gpio_out", model_out, gpio_out);
      check_gpio("gpio_oe", model_dir, gpio_oe);
      bus_read(bit_addr(io_pkg::A_GPIO_OUT), rd);
      check_word("out read-back", io_pkg::word_t'(model_out), rd);
      bus_read(bit_addr(io_pkg::A_GPIO_DIR), rd);
      check_word("dir read-back", io_pkg::word_t'(model_dir), rd);
    end
  endtask

  task automatic input_read_test();
    io_pkg::word_t     rd;
    logic [GPIO_W-1:0] pins;
    test_name = "input_read";
    for (int i = 0; i < 4; i++) begin
      rd      = rand_word();
      pins    = rd[GPIO_W-1:0];
      gpio_in = pins;
      idle_cycles(2);  // Sample register plus margin
      bus_read(bit_addr(io_pkg::A_GPIO_IN), rd);
      check_word("in read-back", io_pkg::word_t'(pins), rd);
      // Two sources selected, read data is their OR
      bus_read(bit_addr(io_pkg::A_GPIO_IN) | bit_addr(io_pkg::A_GPIO_OUT), rd);
      check_word("in|out read-back", io_pkg::word_t'(pins | model_out), rd);
    end
  endtask

  task automatic timer_test();
    io_pkg::word_t rd;
    io_pkg::word_t first;
    int            edges;
    int            gap;
    test_name = "timer";
    bus_write(bit_addr(io_pkg::A_TICKS), 16'hFFF0);
    edges = 0;
    while (!interrupt && edges < 64) begin
      @(posedge clk);
      #5;
      edges++;
    end
    if (!interrupt) begin
      $display("Timeout: interrupt never rose after the timer was loaded");
      timeout_errors++;
    end
    check_word("edges to interrupt", 16'd16, io_pkg::word_t'(edges));
    bus_read(bit_addr(io_pkg::A_TICKS), rd);
    check_word("timer after wrap", '0, rd);
    check_bit("interrupt one cycle later", 1'b0, interrupt);
    gap = 3 + int'(rand_word() % 16);
    bus_read(bit_addr(io_pkg::A_CYCLES), first);
    idle_cycles(gap);
    bus_read(bit_addr(io_pkg::A_CYCLES), rd);
    check_word("cycle delta", io_pkg::word_t'(gap + 1), rd - first);  // Read itself takes a cycle
  endtask

  task automatic density_test();
    io_pkg::sub_sel_e sels [3];
    io_pkg::word_t    levels [3];
    int               highs [3];
    io_pkg::word_t    rd;
    test_name = "density";
    sels = '{io_pkg::SEL_SDM_RED, io_pkg::SEL_SDM_GREEN, io_pkg::SEL_SDM_BLUE};
    bus_write(group_addr(io_pkg::SEL_LEDS, io_pkg::OP_WRITE), '0);  // LEDs off
    model_leds = '0;
    for (int round = 0; round < 2; round++) begin
      if (round == 0) begin
        levels = '{rand_word(), rand_word(), rand_word()};
      end else begin
        levels = '{16'h00FF, 16'h0001, 16'h1280};  // Upper bits ignored by the accumulator
      end
      for (int c = 0; c < 3; c++) begin
        bus_write(group_addr(sels[c], io_pkg::OP_WRITE), levels[c]);
        bus_read(group_addr(sels[c], io_pkg::OP_WRITE), rd);
        check_word("level read-back", levels[c], rd);
      end
      // Last write edge is a cycle back, every carry now uses the new levels
      highs = '{0, 0, 0};
      for (int n = 0; n < (1 << SDM_W); n++) begin
        if (led_red) highs[0]++;
        if (led_green) highs[1]++;
        if (led_blue) highs[2]++;
        idle_cycles(1);
      end
      for (int c = 0; c < 3; c++) begin
        check_word($sformatf("colour %0d density", c),
                   levels[c] & io_pkg::word_t'((1 << SDM_W) - 1), io_pkg::word_t'(highs[c]));
      end
    end
  endtask

  task automatic led_override_test();
    io_pkg::modify_op_e op;
    io_pkg::word_t      data;
    io_pkg::word_t      next;
    io_pkg::word_t      rd;
    test_name = "led_override";
    bus_write(group_addr(io_pkg::SEL_SDM_RED, io_pkg::OP_WRITE), '0);
    bus_write(group_addr(io_pkg::SEL_SDM_GREEN, io_pkg::OP_WRITE), '0);
    bus_write(group_addr(io_pkg::SEL_SDM_BLUE, io_pkg::OP_WRITE), '0);
    for (int i = 0; i < 10; i++) begin
      op   = io_pkg::modify_op_e'(i[1:0]);
      data = rand_word();
      if (i == 9) begin
        op   = io_pkg::OP_SET;
        data = 16'h0007;  // All three colours forced on
      end
      bus_write(group_addr(io_pkg::SEL_LEDS, op), data);
      next       = modify_model(io_pkg::word_t'(model_leds), data, op);
      model_leds = next[io_pkg::LED_W-1:0];
      bus_read(group_addr(io_pkg::SEL_LEDS, io_pkg::OP_WRITE), rd);
      check_word("leds read-back", io_pkg::word_t'(model_leds), rd);
      // Levels at 0, so each colour follows its LED bit every cycle
      for (int n = 0; n < 8; n++) begin
        check_bit("led_red", model_leds[0], led_red);
        check_bit("led_green", model_leds[1], led_green);
        check_bit("led_blue", model_leds[2], led_blue);
        idle_cycles(1);
      end
    end
  endtask

  initial begin
    lcg_state      = 32'd93;
    value_errors   = 0;
    timeout_errors = 0;
    model_out      = '0;
    model_dir      = '0;
    model_leds     = '0;
    reset_button   = 1'b1;
    addr           = '0;
    wr_data        = '0;
    wr             = 1'b0;
    gpio_in        = '0;
    repeat (3) @(posedge clk);
    #5;
    reset_button = 1'b0;
    port_modify_test();
    input_read_test();
    timer_test();
    density_test();
    led_override_test();
    $display("Value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/io_pkg.sv
rtl/io_bus_decode.sv
rtl/gpio_port.sv
rtl/tick_timer.sv
rtl/led_modulator.sv
rtl/io_bus_top.sv
test/io_bus_properties.sv
test/io_bus_tb.sv
